// ==== verilog/cpuPkg.sv ====
// Shared types for the execute / memory slice of the pipeline
// ALU operation, load and store encodings, exception flags
// and the packed structs passed between the stages

`default_nettype none

package cpuPkg;

    // ==================================================
    // Operation encodings
    // ==================================================

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluAddu = 4'd1,
        aluSub  = 4'd2,
        aluSubu = 4'd3,
        aluAnd  = 4'd4,
        aluOr   = 4'd5,
        aluXor  = 4'd6,
        aluSlt  = 4'd7,
        aluSltu = 4'd8,
        aluSll  = 4'd9,
        aluSrl  = 4'd10,
        aluSra  = 4'd11,
        aluLui  = 4'd12
    } aluOpT;

    typedef enum logic [2:0] {
        loadNone = 3'd0,
        loadLb   = 3'd1,
        loadLbu  = 3'd2,
        loadLh   = 3'd3,
        loadLhu  = 3'd4,
        loadLw   = 3'd5
    } loadTypeT;

    typedef enum logic [1:0] {
        storeNone = 2'd0,
        storeSb   = 2'd1,
        storeSh   = 2'd2,
        storeSw   = 2'd3
    } storeTypeT;

    typedef struct packed {
        logic overflow;      // Signed add or sub overflowed
        logic addrErrLoad;   // Misaligned load address
        logic addrErrStore;  // Misaligned store address
    } exceptT;

    // ==================================================
    // Stage structs
    // ==================================================

    // Operation as issued by decode, operands already read
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [31:0] storeData;
        aluOpT       aluOp;
        loadTypeT    loadType;
        storeTypeT   storeType;
        logic [4:0]  dst;
        logic        regWrite;
    } exeInT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluOut;     // ALU result or effective address
        logic [31:0] storeData;
        loadTypeT    loadType;
        storeTypeT   storeType;
        logic [4:0]  dst;
        logic        regWrite;
        exceptT      except;
        logic        valid;
    } exeMemT;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dst;
        logic        regWrite;
        exceptT      except;
    } memWbT;

endpackage

`default_nettype wire

// ==== verilog/aluUnit.sv ====
// Execute stage ALU
// Arithmetic, logic, shift and address computation with signed overflow

`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  cpuPkg::exeInT  issue,
    input  logic           issueValid,
    output cpuPkg::exeMemT exeResult
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  shamt;
    logic [31:0] result;
    logic        overflow;

    assign sum   = issue.srcA + issue.srcB;
    assign diff  = issue.srcA - issue.srcB;
    assign shamt = issue.srcB[4:0];

    always_comb begin
        result   = 32'b0;
        overflow = 1'b0;
        unique case (issue.aluOp)
            cpuPkg::aluAdd: begin
                result   = sum;
                overflow = (issue.srcA[31] == issue.srcB[31]) && (sum[31] != issue.srcA[31]);
            end
            cpuPkg::aluAddu: result = sum;  // Also used for load and store addresses
            cpuPkg::aluSub: begin
                result   = diff;
                overflow = (issue.srcA[31] != issue.srcB[31]) && (diff[31] != issue.srcA[31]);
            end
            cpuPkg::aluSubu: result = diff;
            cpuPkg::aluAnd:  result = issue.srcA & issue.srcB;
            cpuPkg::aluOr:   result = issue.srcA | issue.srcB;
            cpuPkg::aluXor:  result = issue.srcA ^ issue.srcB;
            cpuPkg::aluSlt:  result = {31'b0, $signed(issue.srcA) < $signed(issue.srcB)};
            cpuPkg::aluSltu: result = {31'b0, issue.srcA < issue.srcB};
            cpuPkg::aluSll:  result = issue.srcA << shamt;
            cpuPkg::aluSrl:  result = issue.srcA >> shamt;
            cpuPkg::aluSra:  result = $signed(issue.srcA) >>> shamt;
            cpuPkg::aluLui:  result = {issue.srcB[15:0], 16'b0};
            default:         result = 32'b0;
        endcase
    end

    always_comb begin
        exeResult                     = '0;
        exeResult.pc                  = issue.pc;
        exeResult.aluOut              = result;
        exeResult.storeData           = issue.storeData;
        exeResult.loadType            = issue.loadType;
        exeResult.storeType           = issue.storeType;
        exeResult.dst                 = issue.dst;
        exeResult.regWrite            = issue.regWrite && !overflow;  // No write-back on overflow
        exeResult.except.overflow     = overflow;
        exeResult.except.addrErrLoad  = 1'b0;
        exeResult.except.addrErrStore = 1'b0;
        exeResult.valid               = issueValid;
    end

endmodule

`default_nettype wire

// ==== verilog/exeMemReg.sv ====
// EXE/MEM pipeline register
// One packed stage register with write enable and synchronous flush

`timescale 1ns/1ps
`default_nettype none

module exeMemReg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           memWr,
    input  logic           memFlush,
    input  cpuPkg::exeMemT exeResult,
    output cpuPkg::exeMemT memStage
);

    // Flush takes priority over a write on the same edge
    always_ff @(posedge clk) begin
        if (!rstN || memFlush) begin
            memStage <= '0;
        end else if (memWr) begin
            memStage <= exeResult;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memAccess.sv ====
// Memory stage
// Data RAM, store byte lanes, load lane select and extension,
// alignment check and the registered write-back packet

`timescale 1ns/1ps
`default_nettype none

module memAccess #(
    parameter int DataWords = 256
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           wbWr,
    input  cpuPkg::exeMemT memStage,
    output logic           memExcept,
    output cpuPkg::memWbT  wb
);

    localparam int IdxBits = (DataWords > 1) ? $clog2(DataWords) : 1;

    logic [31:0]        ram [DataWords];
    logic [IdxBits-1:0] wordIdx;
    logic [1:0]         byteOff;

    cpuPkg::exceptT curExcept;
    logic           anyExcept;
    logic           misLoad;
    logic           misStore;

    logic [3:0]    byteEn;
    logic [31:0]   wrData;
    logic          doStore;
    logic [31:0]   rdWord;
    logic [31:0]   rdShift;
    logic [31:0]   loadVal;
    cpuPkg::memWbT wbNext;

    assign wordIdx = memStage.aluOut[IdxBits+1:2];  // Wraps modulo DataWords
    assign byteOff = memStage.aluOut[1:0];

    // ==================================================
    // Alignment check
    // ==================================================

    always_comb begin
        unique case (memStage.loadType)
            cpuPkg::loadLh, cpuPkg::loadLhu: misLoad = byteOff[0];
            cpuPkg::loadLw:                  misLoad = (byteOff != 2'b00);
            default:                         misLoad = 1'b0;
        endcase
        unique case (memStage.storeType)
            cpuPkg::storeSh: misStore = byteOff[0];
            cpuPkg::storeSw: misStore = (byteOff != 2'b00);
            default:         misStore = 1'b0;
        endcase
    end

    always_comb begin
        curExcept              = memStage.except;
        curExcept.addrErrLoad  = misLoad;
        curExcept.addrErrStore = misStore;
    end

    assign anyExcept = curExcept.overflow || curExcept.addrErrLoad || curExcept.addrErrStore;
    assign memExcept = memStage.valid && anyExcept;

    // ==================================================
    // Store path
    // ==================================================

    always_comb begin
        unique case (memStage.storeType)
            cpuPkg::storeSb: begin
                byteEn = 4'b0001 << byteOff;
                wrData = {4{memStage.storeData[7:0]}};
            end
            cpuPkg::storeSh: begin
                byteEn = 4'b0011 << {byteOff[1], 1'b0};
                wrData = {2{memStage.storeData[15:0]}};
            end
            cpuPkg::storeSw: begin
                byteEn = 4'b1111;
                wrData = memStage.storeData;
            end
            default: begin
                byteEn = 4'b0000;
                wrData = memStage.storeData;
            end
        endcase
    end

    // Bubbles and excepting stores leave memory untouched
    assign doStore = wbWr && memStage.valid && !anyExcept;

    always_ff @(posedge clk) begin
        if (doStore) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) ram[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
            end
        end
    end

    // ==================================================
    // Load path and write-back packet
    // ==================================================

    assign rdWord  = ram[wordIdx];
    assign rdShift = rdWord >> {byteOff, 3'b000};

    always_comb begin
        unique case (memStage.loadType)
            cpuPkg::loadLb:  loadVal = {{24{rdShift[7]}}, rdShift[7:0]};
            cpuPkg::loadLbu: loadVal = {24'b0, rdShift[7:0]};
            cpuPkg::loadLh:  loadVal = {{16{rdShift[15]}}, rdShift[15:0]};
            cpuPkg::loadLhu: loadVal = {16'b0, rdShift[15:0]};
            cpuPkg::loadLw:  loadVal = rdWord;
            default:         loadVal = memStage.aluOut;
        endcase
    end

    always_comb begin
        wbNext.pc       = memStage.pc;
        wbNext.dst      = memStage.dst;
        wbNext.regWrite = memStage.regWrite && !anyExcept;
        wbNext.except   = curExcept;
        if (memStage.loadType != cpuPkg::loadNone && anyExcept) begin
            wbNext.result = 32'b0;
        end else begin
            wbNext.result = loadVal;
        end
    end

    // Packet payload only, wbValid lives in the control block
    always_ff @(posedge clk) begin
        if (rstN && wbWr) begin
            wb <= wbNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipeCtrl.sv ====
// Pipeline control for the slice
// Freeze on write-back back-pressure, flush after an exception,
// and the write-back valid register

`timescale 1ns/1ps
`default_nettype none

module pipeCtrl (
    input  logic clk,
    input  logic rstN,
    input  logic wbReady,
    input  logic memExcept,
    input  logic memValid,
    output logic issueReady,
    output logic memWr,
    output logic wbWr,
    output logic memFlush,
    output logic wbValid
);

    logic advance;

    // Everything moves unless write-back holds a packet that is not taken
    assign advance = !wbValid || wbReady;

    assign issueReady = advance;
    assign memWr      = advance;
    assign wbWr       = advance;

    // Drop the operation entering EXE/MEM behind an excepting one
    assign memFlush = advance && memExcept;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else if (advance) begin
            wbValid <= memValid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exeMemTop.sv ====
// Top level of the execute / memory slice
// ALU, EXE/MEM register, memory stage and pipeline control

`timescale 1ns/1ps
`default_nettype none

module exeMemTop #(
    parameter int DataWords = 256
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          issueValid,
    input  cpuPkg::exeInT issue,
    output logic          issueReady,
    input  logic          wbReady,
    output logic          wbValid,
    output cpuPkg::memWbT wb
);

    cpuPkg::exeMemT exeResult;
    cpuPkg::exeMemT memStage;
    logic           memWr;
    logic           memFlush;
    logic           wbWr;
    logic           memExcept;

    aluUnit alu (
        .issue      (issue),
        .issueValid (issueValid),
        .exeResult  (exeResult)
    );

    exeMemReg exeMem (
        .clk       (clk),
        .rstN      (rstN),
        .memWr     (memWr),
        .memFlush  (memFlush),
        .exeResult (exeResult),
        .memStage  (memStage)
    );

    memAccess #(
        .DataWords (DataWords)
    ) mem (
        .clk       (clk),
        .rstN      (rstN),
        .wbWr      (wbWr),
        .memStage  (memStage),
        .memExcept (memExcept),
        .wb        (wb)
    );

    pipeCtrl ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .wbReady    (wbReady),
        .memExcept  (memExcept),
        .memValid   (memStage.valid),
        .issueReady (issueReady),
        .memWr      (memWr),
        .wbWr       (wbWr),
        .memFlush   (memFlush),
        .wbValid    (wbValid)
    );

endmodule

`default_nettype wire

// ==== verification/exeMemChecker.sv ====
// Reference model and comparison for the execute / memory slice
// Tracks the EXE/MEM and write-back slots, a model RAM and the squash rule

`timescale 1ns/1ps
`default_nettype none

module exeMemChecker #(
    parameter int DataWords = 256
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          issueValid,
    input  cpuPkg::exeInT issue,
    input  logic          issueReady,
    input  logic          wbReady,
    input  logic          wbValid,
    input  cpuPkg::memWbT wb
);

    logic [31:0]   modelRam [DataWords];
    logic          memV;          // Model of the EXE/MEM valid bit
    logic          wbV;           // Model of wbValid
    cpuPkg::exeInT memOp;
    cpuPkg::memWbT wbExp;
    string         wbName;
    int            accepted = 0;
    int            squashed = 0;
    int            compared = 0;
    int            errors   = 0;

    // ==================================================
    // Reference model
    // ==================================================

    // Returns {signed overflow, 32-bit result}
    function automatic logic [32:0] aluRef(input cpuPkg::exeInT op);
        logic [32:0] w;
        logic [32:0] d;
        logic [31:0] a;
        logic [31:0] b;
        a = op.srcA;
        b = op.srcB;
        w = {a[31], a} + {b[31], b};  // Sign-extended to 33 bits
        d = {a[31], a} - {b[31], b};
        case (op.aluOp)
            cpuPkg::aluAdd:  return {w[32] ^ w[31], w[31:0]};
            cpuPkg::aluAddu: return {1'b0, w[31:0]};
            cpuPkg::aluSub:  return {d[32] ^ d[31], d[31:0]};
            cpuPkg::aluSubu: return {1'b0, d[31:0]};
            cpuPkg::aluAnd:  return {1'b0, a & b};
            cpuPkg::aluOr:   return {1'b0, a | b};
            cpuPkg::aluXor:  return {1'b0, a ^ b};
            cpuPkg::aluSlt:  return {32'b0, $signed(a) < $signed(b)};
            cpuPkg::aluSltu: return {32'b0, a < b};
            cpuPkg::aluSll:  return {1'b0, a << b[4:0]};
            cpuPkg::aluSrl:  return {1'b0, a >> b[4:0]};
            cpuPkg::aluSra:  return {1'b0, $signed(a) >>> b[4:0]};
            cpuPkg::aluLui:  return {1'b0, b[15:0], 16'b0};
            default:         return 33'b0;
        endcase
    endfunction

    function automatic cpuPkg::memWbT refPacket(input cpuPkg::exeInT op);
        cpuPkg::memWbT p;
        logic [32:0]   ar;
        logic [31:0]   lane;
        logic [1:0]    off;
        ar   = aluRef(op);
        off  = ar[1:0];
        lane = modelRam[ar[31:2] % DataWords] >> (8 * off);
        p.pc = op.pc;
        p.dst = op.dst;
        p.except.overflow = ar[32];
        p.except.addrErrLoad = ((op.loadType == cpuPkg::loadLh
                                 || op.loadType == cpuPkg::loadLhu) && off[0])
                               || (op.loadType == cpuPkg::loadLw && off != 2'b00);
        p.except.addrErrStore = (op.storeType == cpuPkg::storeSh && off[0])
                                || (op.storeType == cpuPkg::storeSw && off != 2'b00);
        case (op.loadType)
            cpuPkg::loadLb:  p.result = {{24{lane[7]}}, lane[7:0]};
            cpuPkg::loadLbu: p.result = {24'b0, lane[7:0]};
            cpuPkg::loadLh:  p.result = {{16{lane[15]}}, lane[15:0]};
            cpuPkg::loadLhu: p.result = {16'b0, lane[15:0]};
            cpuPkg::loadLw:  p.result = lane;
            default:         p.result = ar[31:0];
        endcase
        if (op.loadType != cpuPkg::loadNone && p.except != 3'b000) p.result = 32'b0;
        p.regWrite = op.regWrite && (p.except == 3'b000);
        return p;
    endfunction

    task automatic applyStore(input cpuPkg::exeInT op, input logic [31:0] addr);
        int idx;
        int lane;
        idx  = int'(addr[31:2] % DataWords);
        lane = int'(addr[1:0]);
        case (op.storeType)
            cpuPkg::storeSb: modelRam[idx][8*lane +: 8] = op.storeData[7:0];
            cpuPkg::storeSh: modelRam[idx][16*(lane/2) +: 16] = op.storeData[15:0];
            cpuPkg::storeSw: modelRam[idx] = op.storeData;
            default: ;
        endcase
    endtask

    function automatic string opName(input cpuPkg::exeInT op);
        if (op.loadType != cpuPkg::loadNone) return "load";
        if (op.storeType != cpuPkg::storeNone) return "store";
        return "alu";
    endfunction

    // ==================================================
    // Comparison
    // ==================================================

    always @(posedge clk) begin
        logic        adv;
        logic        flush;
        logic [32:0] ar;
        if (!rstN) begin
            memV = 1'b0;
            wbV  = 1'b0;
        end else begin
            adv = !wbV || wbReady;
            if (issueReady !== adv) begin
                errors++;
                $display("issueReady is %b at %0t although the model expects %b",
                         issueReady, $time, adv);
            end
            if (wbValid !== wbV) begin
                errors++;
                $display("wbValid is %b at %0t although the model expects %b",
                         wbValid, $time, wbV);
            end else if (wbV) begin
                // A held packet is compared on every cycle until it is taken
                if (wb !== wbExp) begin
                    errors++;
                    $display("[FAIL] %s at pc %h: expected %h, actual %h",
                             wbName, wbExp.pc, wbExp, wb);
                end
                if (wbReady) compared++;
            end
            if (adv) begin
                flush = 1'b0;
                if (memV) begin
                    wbExp  = refPacket(memOp);
                    wbName = opName(memOp);
                    flush  = (wbExp.except != 3'b000);  // Next operation is squashed
                    ar     = aluRef(memOp);
                    if (!flush) applyStore(memOp, ar[31:0]);
                end
                wbV = memV;
                if (issueValid) accepted++;
                if (issueValid && flush) squashed++;
                memV  = issueValid && !flush;
                memOp = issue;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/exeMemAssertions.sv ====
// Concurrent checks on the pipeline control and the stage it freezes
// Bound into pipeCtrl from the testbench

`timescale 1ns/1ps
`default_nettype none

module exeMemAssertions (
    input logic clk,
    input logic rstN,
    input logic wbReady,
    input logic wbValid,
    input logic memExcept,
    input logic memValid,
    input logic memFlush
);

    resetState: assert property (@(posedge clk)
        $rose(rstN) |-> !wbValid && !memValid && !memFlush)
        else $error("Pipeline not empty when reset was released");

    // A flushed operation never reaches the memory stage
    flushClears: assert property (@(posedge clk) disable iff (!rstN)
        memFlush |=> !memValid)
        else $error("EXE/MEM still holds a valid operation after a flush");

    // The memory stage is frozen while write-back holds a packet
    holdMem: assert property (@(posedge clk) disable iff (!rstN)
        (wbValid && !wbReady) |=> $stable(memValid) && $stable(memExcept))
        else $error("Memory stage changed while write-back was stalled");

endmodule

`default_nettype wire

// ==== verification/exeMemTb.sv ====
// Testbench top for the execute / memory slice
// Clock, reset, LFSR stimulus, timeout and the closing report

`timescale 1ns/1ps
`default_nettype none

module exeMemTb;

    localparam int DataWords  = 256;
    localparam int InitOps    = 16;
    localparam int RandOps    = 400;
    localparam int CycleLimit = 20 * (InitOps + RandOps) + 200;

    logic          clk;
    logic          rstN;
    logic          issueValid;
    cpuPkg::exeInT issue;
    logic          issueReady;
    logic          wbReady;
    logic          wbValid;
    cpuPkg::memWbT wb;
    logic [31:0]   lfsr   = 32'h8cfddee0;
    int            cycles = 0;

    exeMemTop #(.DataWords(DataWords)) dut (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issue      (issue),
        .issueReady (issueReady),
        .wbReady    (wbReady),
        .wbValid    (wbValid),
        .wb         (wb)
    );

    exeMemChecker #(.DataWords(DataWords)) chk (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issue      (issue),
        .issueReady (issueReady),
        .wbReady    (wbReady),
        .wbValid    (wbValid),
        .wb         (wb)
    );

    bind pipeCtrl exeMemAssertions asrt (
        .clk       (clk),
        .rstN      (rstN),
        .wbReady   (wbReady),
        .wbValid   (wbValid),
        .memExcept (memExcept),
        .memValid  (memValid),
        .memFlush  (memFlush)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randBits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic driveReady(input logic allowStall);
        logic [31:0] r;
        randBits(2, r);
        wbReady = !allowStall || (r[1:0] != 2'b00);  // Low about a quarter of the time
    endtask

    task automatic idleCycle();
        issueValid = 1'b0;
        driveReady(1'b1);
        @(posedge clk);
        #1;
    endtask

    // Holds the operation until it is accepted at a rising edge
    task automatic issueOp(input cpuPkg::exeInT op, input logic allowStall);
        logic taken;
        taken      = 1'b0;
        issue      = op;
        issueValid = 1'b1;
        while (!taken) begin
            driveReady(allowStall);
            #6;
            taken = issueReady;
            @(posedge clk);
            #1;
        end
        issueValid = 1'b0;
    endtask

    task automatic makeOp(input int seq, output cpuPkg::exeInT op);
        logic [31:0] r;
        logic [31:0] kind;
        op    = '0;
        op.pc = 32'h0040_0000 + 4 * seq;
        randBits(5, r);
        op.dst = r[4:0];
        randBits(3, kind);
        if (kind < 5) begin
            randBits(4, r);
            op.aluOp = cpuPkg::aluOpT'(4'(r % 13));
            randBits(32, r);
            op.srcA = r;
            randBits(32, r);
            op.srcB = r;
            randBits(1, r);
            op.regWrite = r[0];
        end else begin
            op.aluOp = cpuPkg::aluAddu;  // Effective address, words 0 to 15
            randBits(4, r);
            op.srcA = {26'b0, r[3:0], 2'b00};
            randBits(2, r);
            op.srcB = {30'b0, r[1:0]};
            randBits(32, r);
            op.storeData = r;
            randBits(3, r);
            if (kind == 6) begin
                op.storeType = cpuPkg::storeTypeT'(2'(r % 3 + 1));
            end else begin
                op.loadType = cpuPkg::loadTypeT'(3'(r % 5 + 1));
                op.regWrite = 1'b1;
            end
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        cpuPkg::exeInT op;
        logic [31:0]   r;
        int            countErrors;
        rstN       = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        wbReady    = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        // Word stores back to back fill every word the loads can reach
        for (int i = 0; i < InitOps; i++) begin
            op           = '0;
            op.pc        = 32'h0040_0000 + 4 * i;
            op.aluOp     = cpuPkg::aluAddu;
            op.srcA      = 4 * i;
            op.storeType = cpuPkg::storeSw;
            randBits(32, r);
            op.storeData = r;
            issueOp(op, 1'b0);
        end
        for (int i = 0; i < RandOps; i++) begin
            randBits(2, r);
            if (r[1:0] == 2'b00) idleCycle();
            makeOp(InitOps + i, op);
            issueOp(op, 1'b1);
        end
        wbReady = 1'b1;
        repeat (4) @(posedge clk);  // Two-stage latency plus margin
        #1;
        countErrors = 0;
        if (chk.accepted != chk.compared + chk.squashed) begin
            countErrors = 1;
            $display("Packets lost or duplicated: %0d accepted but %0d written back",
                     chk.accepted, chk.compared + chk.squashed);
        end
        $display("Accepted %0d, written back %0d, squashed %0d, errors %0d",
                 chk.accepted, chk.compared, chk.squashed, chk.errors + countErrors);
        if (chk.errors + countErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        while (cycles < CycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles before all operations finished", cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/cpuPkg.sv
verilog/aluUnit.sv
verilog/exeMemReg.sv
verilog/memAccess.sv
verilog/pipeCtrl.sv
verilog/exeMemTop.sv
verification/exeMemChecker.sv
verification/exeMemAssertions.sv
verification/exeMemTb.sv

// ==== Bender.yml ====
package:
  name: exe_mem_slice

sources:
  - verilog/cpuPkg.sv
  - verilog/aluUnit.sv
  - verilog/exeMemReg.sv
  - verilog/memAccess.sv
  - verilog/pipeCtrl.sv
  - verilog/exeMemTop.sv
  - target: test
    files:
      - verification/exeMemChecker.sv
      - verification/exeMemAssertions.sv
      - verification/exeMemTb.sv
